/* logic/soc_pkg.sv */
// Address map and bus types for the host subsystem. Accesses move whole 64-bit words only
package soc_pkg;

  // --------------------------------------------------------------------------
  // Widths and bus types
  // --------------------------------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    TargetRom,
    TargetClint,
    TargetL2,
    TargetNone
  } target_e;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  // Each window runs from base up to base plus length, end excluded
  localparam addr_t RomBase     = 32'h0001_0000;
  localparam addr_t RomLength   = 32'h0001_0000;
  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h0000_C000;
  localparam addr_t L2Base      = 32'h1C00_0000;
  localparam addr_t L2Length    = 32'h0010_0000;

  // CLINT register offsets
  localparam addr_t MsipOffset     = 32'h0000_0000;
  localparam addr_t MtimecmpOffset = 32'h0000_4000;
  localparam addr_t MtimeOffset    = 32'h0000_BFF8;

  // --------------------------------------------------------------------------
  // Boot ROM
  // --------------------------------------------------------------------------
  localparam int unsigned RomWords = 8;
  typedef logic [$clog2(RomWords)-1:0] rom_idx_t;

  localparam data_t RomContent [RomWords] = '{
    64'h0000_0517_f140_2573,
    64'h0285_8593_0000_0597,
    64'h1c00_02b7_0000_0013,
    64'h0002_8067_0000_0013,
    64'h0000_0013_1050_0073,
    64'hffdf_f06f_0000_0013,
    // Jump target and device tree pointer
    64'h0000_0000_1c00_0000,
    64'h0000_0000_0001_0040
  };

  // Debug requests held back this many cycles after reset
  localparam int unsigned DebugDelayCycles = 500;
  typedef logic [$clog2(DebugDelayCycles+1)-1:0] dbg_cnt_t;

endpackage

/* logic/addr_decoder.sv */
// Purely combinational lookup. The first matching window wins and windows must not overlap
module addr_decoder (
  input  soc_pkg::addr_t   addr_i,
  output soc_pkg::target_e target_o
);

  // Half-open window check
  function automatic logic in_window(
    soc_pkg::addr_t addr,
    soc_pkg::addr_t base,
    soc_pkg::addr_t length
  );
    return (addr >= base) && (addr < base + length);
  endfunction

  logic hit_rom;
  logic hit_clint;
  logic hit_l2;

  assign hit_rom   = in_window(addr_i, soc_pkg::RomBase, soc_pkg::RomLength);
  assign hit_clint = in_window(addr_i, soc_pkg::ClintBase, soc_pkg::ClintLength);
  assign hit_l2    = in_window(addr_i, soc_pkg::L2Base, soc_pkg::L2Length);

  always_comb begin
    if (hit_rom) begin
      target_o = soc_pkg::TargetRom;
    end else if (hit_clint) begin
      target_o = soc_pkg::TargetClint;
    end else if (hit_l2) begin
      target_o = soc_pkg::TargetL2;
    end else begin
      // No rule matched
      target_o = soc_pkg::TargetNone;
    end
  end

endmodule

/* logic/bus_router.sv */
// Single host router. Every target must answer exactly one cycle after its request
module bus_router (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  soc_pkg::mem_req_t host_req_i,
  output soc_pkg::mem_rsp_t host_rsp_o,
  output soc_pkg::mem_req_t rom_req_o,
  output soc_pkg::mem_req_t clint_req_o,
  output soc_pkg::mem_req_t l2_req_o,
  input  soc_pkg::mem_rsp_t rom_rsp_i,
  input  soc_pkg::mem_rsp_t clint_rsp_i,
  input  soc_pkg::mem_rsp_t l2_rsp_i
);

  soc_pkg::target_e target;
  soc_pkg::target_e target_q;
  logic             req_q;

  addr_decoder addr_decoder_i (
    .addr_i   ( host_req_i.addr ),
    .target_o ( target          )
  );

  // --------------------------------------------------------------------------
  // Request steering
  // --------------------------------------------------------------------------
  // Payload goes everywhere, only the decoded target sees req
  always_comb begin
    rom_req_o       = host_req_i;
    clint_req_o     = host_req_i;
    l2_req_o        = host_req_i;
    rom_req_o.req   = host_req_i.req && (target == soc_pkg::TargetRom);
    clint_req_o.req = host_req_i.req && (target == soc_pkg::TargetClint);
    l2_req_o.req    = host_req_i.req && (target == soc_pkg::TargetL2);
  end

  // Remember who owes the response next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      target_q <= soc_pkg::TargetNone;
      req_q    <= 1'b0;
    end else begin
      target_q <= target;
      req_q    <= host_req_i.req;
    end
  end

  // --------------------------------------------------------------------------
  // Response selection
  // --------------------------------------------------------------------------
  always_comb begin
    host_rsp_o = '0;
    if (req_q) begin
      case (target_q)
        soc_pkg::TargetRom:   host_rsp_o = rom_rsp_i;
        soc_pkg::TargetClint: host_rsp_o = clint_rsp_i;
        soc_pkg::TargetL2:    host_rsp_o = l2_rsp_i;
        default: begin
          // Decode miss answered locally
          host_rsp_o.valid = 1'b1;
          host_rsp_o.err   = 1'b1;
        end
      endcase
    end
  end

endmodule

/* logic/boot_rom.sv */
// Read-only table of RomWords words. Writes are dropped and reads past the table return zero
module boot_rom (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  soc_pkg::mem_req_t req_i,
  output soc_pkg::mem_rsp_t rsp_o
);

  soc_pkg::addr_t    offset;
  soc_pkg::rom_idx_t idx;
  logic              in_table;
  logic              valid_q;
  soc_pkg::data_t    rdata_q;

  assign offset   = req_i.addr - soc_pkg::RomBase;
  assign idx      = offset[3 +: $bits(soc_pkg::rom_idx_t)];
  assign in_table = offset < soc_pkg::addr_t'(soc_pkg::RomWords * 8);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= (!req_i.we && in_table) ? soc_pkg::RomContent[idx] : '0;
    end
  end

  assign rsp_o = '{valid: valid_q, err: 1'b0, rdata: rdata_q};

endmodule

/* logic/clint_timer.sv */
// Single hart CLINT. rtc_i must be much slower than clk_i so that no edge is lost in sync
module clint_timer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rtc_i,
  input  soc_pkg::mem_req_t req_i,
  output soc_pkg::mem_rsp_t rsp_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  soc_pkg::addr_t offset;
  logic           sel_msip;
  logic           sel_mtimecmp;
  logic           sel_mtime;
  logic           wr_en;
  logic           rtc_rise;
  logic [2:0]     rtc_q;
  soc_pkg::data_t rd_data;

  soc_pkg::data_t msip_q;
  soc_pkg::data_t mtimecmp_q;
  soc_pkg::data_t mtime_q;
  logic           valid_q;
  soc_pkg::data_t rdata_q;

  // --------------------------------------------------------------------------
  // Register decode
  // --------------------------------------------------------------------------
  assign offset       = req_i.addr - soc_pkg::ClintBase;
  assign sel_msip     = offset == soc_pkg::MsipOffset;
  assign sel_mtimecmp = offset == soc_pkg::MtimecmpOffset;
  assign sel_mtime    = offset == soc_pkg::MtimeOffset;
  assign wr_en        = req_i.req && req_i.we;

  always_comb begin
    rd_data = '0;
    if (sel_msip) begin
      rd_data = msip_q;
    end else if (sel_mtimecmp) begin
      rd_data = mtimecmp_q;
    end else if (sel_mtime) begin
      rd_data = mtime_q;
    end
  end

  // --------------------------------------------------------------------------
  // RTC edge detect
  // --------------------------------------------------------------------------
  // Two sync stages, third stage only remembers the last level
  assign rtc_rise = rtc_q[1] && !rtc_q[2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q      <= '0;
      msip_q     <= '0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
      valid_q    <= 1'b0;
    end else begin
      rtc_q   <= {rtc_q[1:0], rtc_i};
      valid_q <= req_i.req;
      if (wr_en && sel_msip) begin
        msip_q <= req_i.wdata;
      end
      if (wr_en && sel_mtimecmp) begin
        mtimecmp_q <= req_i.wdata;
      end
      // Software write beats the tick
      if (wr_en && sel_mtime) begin
        mtime_q <= req_i.wdata;
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : rd_data;
    end
  end

  assign rsp_o       = '{valid: valid_q, err: 1'b0, rdata: rdata_q};
  assign timer_irq_o = mtime_q >= mtimecmp_q;
  assign ipi_o       = msip_q[0];

endmodule

/* logic/debug_req_gate.sv */
// Holds debug_req_o low for DebugDelayCycles cycles after reset release so boot code runs first
module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  output logic debug_req_o
);

  soc_pkg::dbg_cnt_t cnt_q;

  // Counts down once and then sits at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= soc_pkg::dbg_cnt_t'(soc_pkg::DebugDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) ? debug_req_i : 1'b0;

endmodule

/* logic/soc_subsystem.sv */
// Host subsystem top. The external L2 port must answer one cycle after each request
module soc_subsystem (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rtc_i,
  input  soc_pkg::mem_req_t host_req_i,
  output soc_pkg::mem_rsp_t host_rsp_o,
  output soc_pkg::mem_req_t l2_req_o,
  input  soc_pkg::mem_rsp_t l2_rsp_i,
  input  logic              debug_req_i,
  output logic              debug_req_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  soc_pkg::mem_req_t rom_req;
  soc_pkg::mem_rsp_t rom_rsp;
  soc_pkg::mem_req_t clint_req;
  soc_pkg::mem_rsp_t clint_rsp;

  // --------------------------------------------------------------------------
  // Bus
  // --------------------------------------------------------------------------
  bus_router bus_router_i (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .host_req_i  ( host_req_i ),
    .host_rsp_o  ( host_rsp_o ),
    .rom_req_o   ( rom_req    ),
    .clint_req_o ( clint_req  ),
    .l2_req_o    ( l2_req_o   ),
    .rom_rsp_i   ( rom_rsp    ),
    .clint_rsp_i ( clint_rsp  ),
    .l2_rsp_i    ( l2_rsp_i   )
  );

  // --------------------------------------------------------------------------
  // Targets
  // --------------------------------------------------------------------------
  boot_rom boot_rom_i (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .req_i  ( rom_req ),
    .rsp_o  ( rom_rsp )
  );

  clint_timer clint_timer_i (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .rsp_o       ( clint_rsp   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // Debug halt hold-off
  debug_req_gate debug_req_gate_i (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

/* test/tb_clock_gen.sv */
// Free-running 100 ns clock. Reset is released by a non-blocking write after the eighth edge
module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Hold reset for 8 rising edges
  initial begin
    rst_no <= 1'b0;
    repeat (8) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* test/tb_soc_subsystem.sv */
// Needs timing control and concurrent assertions. The L2 model decodes address bits 8:3 only
module tb_soc_subsystem;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {
    ChkNone,
    ChkExact,
    ChkNonzero
  } chk_e;

  logic              clk;
  logic              rst_n;
  logic              rtc;
  logic              dbg_in;
  logic              dbg_out;
  logic              timer_irq;
  logic              ipi;
  soc_pkg::mem_req_t host_req;
  soc_pkg::mem_rsp_t host_rsp;
  soc_pkg::mem_req_t l2_req;
  soc_pkg::mem_rsp_t l2_rsp;
  soc_pkg::data_t    l2_mem [64];

  // Expected response travels one stage behind the request
  chk_e              chk_d;
  chk_e              chk_q;
  soc_pkg::mem_rsp_t exp_d;
  soc_pkg::mem_rsp_t exp_q;
  logic              req_q;
  logic              ipi_exp_q;
  logic              cmp_set_q;
  int unsigned       cyc_q;
  int unsigned       err_cnt = 0;
  int unsigned       pass_cnt = 0;
  int unsigned       fail_cnt = 0;

  tb_clock_gen tb_clock_gen_i (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  soc_subsystem soc_subsystem_i (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .rtc_i       ( rtc       ),
    .host_req_i  ( host_req  ),
    .host_rsp_o  ( host_rsp  ),
    .l2_req_o    ( l2_req    ),
    .l2_rsp_i    ( l2_rsp    ),
    .debug_req_i ( dbg_in    ),
    .debug_req_o ( dbg_out   ),
    .timer_irq_o ( timer_irq ),
    .ipi_o       ( ipi       )
  );

  function automatic logic addr_in_range(soc_pkg::addr_t addr, soc_pkg::addr_t base,
                                         soc_pkg::addr_t len);
    return (addr >= base) && (addr < base + len);
  endfunction

  function automatic logic addr_misses(soc_pkg::addr_t addr);
    return !addr_in_range(addr, soc_pkg::RomBase, soc_pkg::RomLength) &&
           !addr_in_range(addr, soc_pkg::ClintBase, soc_pkg::ClintLength) &&
           !addr_in_range(addr, soc_pkg::L2Base, soc_pkg::L2Length);
  endfunction

  // Host request as the L2 port should show it
  function automatic soc_pkg::mem_req_t l2_expect(soc_pkg::mem_req_t req);
    soc_pkg::mem_req_t exp;
    exp     = req;
    exp.req = req.req && addr_in_range(req.addr, soc_pkg::L2Base, soc_pkg::L2Length);
    return exp;
  endfunction

  task automatic flag_mismatch(string sig, logic [127:0] exp, logic [127:0] got);
    err_cnt++;
    $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp, got);
  endtask

  task automatic flag_failure(string what);
    err_cnt++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  // --------------------------------------------------------------------------
  // L2 model and reference state
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      l2_rsp <= '0;
    end else begin
      l2_rsp <= '{valid: l2_req.req, err: 1'b0, rdata: '0};
      if (l2_req.req && l2_req.we) begin
        l2_mem[l2_req.addr[8:3]] <= l2_req.wdata;
      end else if (l2_req.req) begin
        l2_rsp.rdata <= l2_mem[l2_req.addr[8:3]];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q     <= 1'b0;
      chk_q     <= ChkNone;
      exp_q     <= '0;
      ipi_exp_q <= 1'b0;
      cmp_set_q <= 1'b0;
      cyc_q     <= 0;
    end else begin
      req_q <= host_req.req;
      chk_q <= chk_d;
      exp_q <= exp_d;
      cyc_q <= cyc_q + 1;
      if (host_req.req && host_req.we) begin
        if (host_req.addr == soc_pkg::ClintBase + soc_pkg::MsipOffset) begin
          ipi_exp_q <= host_req.wdata[0];
        end
        if (host_req.addr == soc_pkg::ClintBase + soc_pkg::MtimecmpOffset) begin
          cmp_set_q <= 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  latency_a: assert property (@(posedge clk) disable iff (!rst_n) host_rsp.valid == req_q)
    else flag_mismatch("host_rsp_o.valid", 128'($sampled(req_q)), 128'($sampled(host_rsp.valid)));

  rsp_exact_a: assert property (@(posedge clk) disable iff (!rst_n)
    (chk_q == ChkExact) |-> (host_rsp.err == exp_q.err && host_rsp.rdata == exp_q.rdata))
    else flag_mismatch("host_rsp_o.{err,rdata}", 128'({$sampled(exp_q.err), $sampled(exp_q.rdata)}),
                       128'({$sampled(host_rsp.err), $sampled(host_rsp.rdata)}));

  rsp_nonzero_a: assert property (@(posedge clk) disable iff (!rst_n)
    (chk_q == ChkNonzero) |-> (!host_rsp.err && host_rsp.rdata != '0))
    else flag_failure("mtime read back as zero or with the error flag set");

  l2_port_a: assert property (@(posedge clk) disable iff (!rst_n) l2_req == l2_expect(host_req))
    else flag_mismatch("l2_req_o", 128'(l2_expect($sampled(host_req))), 128'($sampled(l2_req)));

  miss_quiet_a: assert property (@(posedge clk) disable iff (!rst_n)
    (host_req.req && addr_misses(host_req.addr)) |->
      !(soc_subsystem_i.rom_req.req || soc_subsystem_i.clint_req.req))
    else flag_failure("a request outside all windows reached the ROM or the CLINT");

  ipi_a: assert property (@(posedge clk) disable iff (!rst_n) ipi == ipi_exp_q)
    else flag_mismatch("ipi_o", 128'($sampled(ipi_exp_q)), 128'($sampled(ipi)));

  timer_idle_a: assert property (@(posedge clk) disable iff (!rst_n) !cmp_set_q |-> !timer_irq)
    else flag_mismatch("timer_irq_o", 128'(0), 128'($sampled(timer_irq)));

  debug_gate_a: assert property (@(posedge clk) disable iff (!rst_n)
    dbg_out == (cyc_q >= soc_pkg::DebugDelayCycles))
    else flag_mismatch("debug_req_o", 128'($sampled(cyc_q) >= soc_pkg::DebugDelayCycles),
                       128'($sampled(dbg_out)));

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  task automatic send(logic we, soc_pkg::addr_t addr, soc_pkg::data_t wdata, chk_e chk,
                      soc_pkg::data_t rdata, logic err);
    @(posedge clk);
    host_req <= '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    chk_d    <= chk;
    exp_d    <= '{valid: 1'b1, err: err, rdata: rdata};
  endtask

  task automatic idle(int unsigned cycles);
    repeat (cycles) begin
      @(posedge clk);
      host_req <= '0;
      chk_d    <= ChkNone;
    end
  endtask

  task automatic close_test(string name, int unsigned errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("Test %s passed", name);
    end else begin
      fail_cnt++;
      $display("Test %s failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  initial begin
    soc_pkg::data_t ref_mem [64];
    int unsigned    wr_idx [8];
    int unsigned    errs;
    int unsigned    waited;
    int unsigned    edges;

    host_req <= '0;
    chk_d    <= ChkNone;
    exp_d    <= '0;
    rtc      <= 1'b0;
    dbg_in   <= 1'b1;
    void'($urandom(67107));

    waited = 0;
    while (rst_n !== 1'b1 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      flag_failure("reset was never released");
    end

    // Back-to-back requests to every target and then a lone one
    errs = err_cnt;
    send(1'b0, soc_pkg::RomBase, '0, ChkNone, '0, 1'b0);
    send(1'b0, soc_pkg::ClintBase + soc_pkg::MtimeOffset, '0, ChkNone, '0, 1'b0);
    send(1'b0, soc_pkg::L2Base, '0, ChkNone, '0, 1'b0);
    send(1'b0, 32'h0000_0000, '0, ChkExact, '0, 1'b1);
    idle(2);
    send(1'b0, soc_pkg::RomBase + 32'h8, '0, ChkNone, '0, 1'b0);
    idle(3);
    close_test("latency", errs);

    errs = err_cnt;
    for (int i = 0; i < soc_pkg::RomWords; i++) begin
      send(1'b0, soc_pkg::RomBase + soc_pkg::addr_t'(8 * i), '0, ChkExact,
           soc_pkg::RomContent[i], 1'b0);
    end
    send(1'b0, soc_pkg::RomBase + 32'h40, '0, ChkExact, '0, 1'b0);
    send(1'b1, soc_pkg::RomBase, {$urandom, $urandom}, ChkExact, '0, 1'b0);
    idle(3);
    close_test("rom_read", errs);

    errs = err_cnt;
    for (int i = 0; i < 8; i++) begin
      wr_idx[i]          = $urandom_range(63);
      ref_mem[wr_idx[i]] = {$urandom, $urandom};
      send(1'b1, soc_pkg::L2Base + soc_pkg::addr_t'(wr_idx[i] * 8), ref_mem[wr_idx[i]],
           ChkExact, '0, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      send(1'b0, soc_pkg::L2Base + soc_pkg::addr_t'(wr_idx[i] * 8), '0, ChkExact,
           ref_mem[wr_idx[i]], 1'b0);
    end
    idle(3);
    close_test("l2_pass_through", errs);

    errs = err_cnt;
    send(1'b0, soc_pkg::RomBase + soc_pkg::RomLength, '0, ChkExact, '0, 1'b1);
    send(1'b1, soc_pkg::ClintBase + soc_pkg::ClintLength, {$urandom, $urandom}, ChkExact,
         '0, 1'b1);
    send(1'b0, 32'h8000_0000 | ($urandom & 32'h0fff_fff8), '0, ChkExact, '0, 1'b1);
    idle(3);
    close_test("decode_miss", errs);

    errs = err_cnt;
    send(1'b1, soc_pkg::ClintBase + soc_pkg::MsipOffset, 64'h1, ChkExact, '0, 1'b0);
    send(1'b0, soc_pkg::ClintBase + soc_pkg::MsipOffset, '0, ChkExact, 64'h1, 1'b0);
    send(1'b1, soc_pkg::ClintBase + soc_pkg::MtimecmpOffset, 64'd3, ChkExact, '0, 1'b0);
    send(1'b0, soc_pkg::ClintBase + soc_pkg::MtimecmpOffset, '0, ChkExact, 64'd3, 1'b0);
    idle(3);
    @(negedge clk);
    // Slow rtc with one edge every 4 clocks
    edges = 0;
    while (!timer_irq && edges < 20) begin
      repeat (4) @(posedge clk);
      rtc <= ~rtc;
      edges++;
      @(negedge clk);
    end
    if (!timer_irq) begin
      flag_failure("timer_irq_o did not rise within 20 rtc edges");
    end
    send(1'b0, soc_pkg::ClintBase + soc_pkg::MtimeOffset, '0, ChkNonzero, '0, 1'b0);
    idle(3);
    close_test("clint", errs);

    errs = err_cnt;
    waited = 0;
    while (cyc_q < soc_pkg::DebugDelayCycles + 10 && waited < 1000) begin
      @(negedge clk);
      waited++;
    end
    if (cyc_q < soc_pkg::DebugDelayCycles + 10) begin
      flag_failure("cycle count did not pass the debug hold window");
    end
    close_test("debug_gate", errs);

    $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
logic/soc_pkg.sv
logic/addr_decoder.sv
logic/bus_router.sv
logic/boot_rom.sv
logic/clint_timer.sv
logic/debug_req_gate.sv
logic/soc_subsystem.sv
test/tb_clock_gen.sv
test/tb_soc_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_soc_subsystem
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
